//--- bru_defines.svh
`ifndef BRU_DEFINES_SVH
`define BRU_DEFINES_SVH

// Entries in each of the two queues
`define BRU_DEPTH 4

// Rename tag carried by register reads and result buses
`define BRU_TAG_W 5

// Predictor history pattern returned at commit
`define BRU_PATTERN_W 8

// Instruction address to restart from when the prediction fails
`define BRU_ADDR_W 14

`endif

//--- bru_pkg.sv
`default_nettype none

`include "bru_defines.svh"

package bru_pkg;

	// A register read or a result-bus word
	typedef struct packed {
		logic valid;
		logic [`BRU_TAG_W-1:0] tag;
		logic [31:0] data;
	} opd_t;

	// CMP_E and CMP_LE work on integers, the other two on floats
	typedef enum logic [1:0] {
		CMP_FZ,
		CMP_FLE,
		CMP_E,
		CMP_LE
	} cmp_kind_t;

	typedef struct packed {
		cmp_kind_t kind;
		opd_t [1:0] opd;
	} cmp_entry_t;

	typedef struct packed {
		logic pred_or_fail; // Prediction until resolved, failure flag after
		logic [`BRU_PATTERN_W-1:0] pattern;
		logic [`BRU_ADDR_W-1:0] addr;
	} outcome_entry_t;

	function automatic logic tag_match(opd_t bus, logic [`BRU_TAG_W-1:0] tag);
		return bus.valid && (bus.tag == tag);
	endfunction

endpackage

`default_nettype wire

//--- bru_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cmp_dispatch_if
	import bru_pkg::*;
();

	logic fire; // Head compare leaves the queue at the next edge
	cmp_kind_t kind;
	logic [31:0] a;
	logic [31:0] b;
	logic taken;

	modport queue (output fire, kind, a, b);

	modport eval (input kind, a, b, output taken);

	modport ctrl (input fire);

	modport outcome (input fire, taken);

endinterface

`default_nettype wire

//--- branch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "bru_defines.svh"

module branch_ctrl (
	input logic clk,
	input logic rst_n,
	input logic issue_valid,
	output logic issue_ready,
	input logic commit_valid,
	output logic commit_ready,
	cmp_dispatch_if.ctrl disp,
	output logic issue_fire,
	output logic commit_fire,
	output logic [2:0] cmp_count,
	output logic [2:0] outcome_count
);

	// Every branch still waiting for its compare also sits in the outcome queue,
	// so the two counts differ exactly by the resolved branches at the head
	assign commit_ready = (outcome_count != cmp_count);
	assign commit_fire = commit_valid && commit_ready;

	// A commit in the same cycle frees the slot the new branch needs
	assign issue_ready = (outcome_count < 3'(`BRU_DEPTH)) || commit_fire;
	assign issue_fire = issue_valid && issue_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cmp_count <= '0;
			outcome_count <= '0;
		end else begin
			cmp_count <= cmp_count + 3'(issue_fire) - 3'(disp.fire);
			outcome_count <= outcome_count + 3'(issue_fire) - 3'(commit_fire);
		end
	end

endmodule

`default_nettype wire

//--- cmp_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "bru_defines.svh"

module cmp_queue
	import bru_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic issue_fire,
	input cmp_kind_t kind,
	input logic use_imm,
	input logic [15:0] imm,
	input opd_t gpr_read [2],
	input opd_t fpr_read [2],
	input opd_t gpr_cdb,
	input opd_t fpr_cdb,
	input logic [2:0] cmp_count,
	cmp_dispatch_if.queue disp
);

	cmp_entry_t q [`BRU_DEPTH];
	cmp_entry_t upd [`BRU_DEPTH];
	cmp_entry_t new_entry;
	opd_t new_bus;
	logic new_int;
	logic [2:0] fill;

	function automatic logic is_int(cmp_kind_t k);
		return (k == CMP_E) || (k == CMP_LE);
	endfunction

	// Picks up a pending operand when its tag shows up on the bus
	function automatic opd_t snoop(opd_t o, opd_t bus);
		opd_t r;
		r = o;
		if (!o.valid && tag_match(bus, o.tag)) begin
			r.valid = 1'b1;
			r.data = bus.data;
		end
		return r;
	endfunction

	assign new_int = is_int(kind);
	assign new_bus = new_int ? gpr_cdb : fpr_cdb;

	always_comb begin
		new_entry.kind = kind;
		for (int j = 0; j < 2; j++) begin
			new_entry.opd[j] = snoop(new_int ? gpr_read[j] : fpr_read[j], new_bus);
		end
		if (new_int && use_imm) begin // Immediate replaces the second register
			new_entry.opd[1].valid = 1'b1;
			new_entry.opd[1].data = {{16{imm[15]}}, imm};
		end
	end

	// Each held entry listens only to the bus of its own kind
	always_comb begin
		for (int i = 0; i < `BRU_DEPTH; i++) begin
			upd[i].kind = q[i].kind;
			for (int j = 0; j < 2; j++) begin
				upd[i].opd[j] = snoop(q[i].opd[j], is_int(q[i].kind) ? gpr_cdb : fpr_cdb);
			end
		end
	end

	// The float is-zero test reads only the first operand
	assign disp.fire = (cmp_count != 3'd0) && q[0].opd[0].valid &&
		((q[0].kind == CMP_FZ) || q[0].opd[1].valid);
	assign disp.kind = q[0].kind;
	assign disp.a = q[0].opd[0].data;
	assign disp.b = q[0].opd[1].data;

	assign fill = cmp_count - 3'(disp.fire); // Entries that stay after the shift

	for (genvar i = 0; i < `BRU_DEPTH; i++) begin : g_slot
		cmp_entry_t shifted;

		if (i < `BRU_DEPTH - 1) begin : g_mid
			assign shifted = disp.fire ? upd[i+1] : upd[i];
		end else begin : g_last
			assign shifted = upd[i];
		end

		always_ff @(posedge clk) begin
			if (!rst_n) begin
				q[i] <= '0;
			end else if (3'(i) < fill) begin
				q[i] <= shifted;
			end else if (issue_fire && (3'(i) == fill)) begin
				q[i] <= new_entry;
			end
		end
	end

endmodule

`default_nettype wire

//--- cmp_eval.sv
`timescale 1ns/1ps
`default_nettype none

module cmp_eval
	import bru_pkg::*;
(
	cmp_dispatch_if.eval disp
);

	logic a_sign;
	logic b_sign;
	logic [30:0] a_mag;
	logic [30:0] b_mag;
	logic both_zero;
	logic fle;

	assign a_sign = disp.a[31];
	assign b_sign = disp.b[31];
	assign a_mag = disp.a[30:0];
	assign b_mag = disp.b[30:0];
	assign both_zero = (a_mag == 31'd0) && (b_mag == 31'd0); // +0 and -0 compare equal

	// Exponent and mantissa together order like an unsigned integer,
	// so only the sign needs special handling
	always_comb begin
		if (both_zero) begin
			fle = 1'b1;
		end else if (a_sign != b_sign) begin
			fle = a_sign; // Negative side is the smaller one
		end else if (!a_sign) begin
			fle = (a_mag <= b_mag);
		end else begin
			fle = (a_mag >= b_mag); // Larger magnitude is more negative
		end
	end

	always_comb begin
		case (disp.kind)
			CMP_E: disp.taken = (disp.a == disp.b);
			CMP_LE: disp.taken = ($signed(disp.a) <= $signed(disp.b));
			CMP_FZ: disp.taken = (disp.a[30:23] == 8'd0);
			CMP_FLE: disp.taken = fle;
			default: disp.taken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- outcome_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "bru_defines.svh"

module outcome_queue
	import bru_pkg::*;
(
	input logic clk,
	input logic issue_fire,
	input logic commit_fire,
	input logic prediction,
	input logic [`BRU_PATTERN_W-1:0] pattern_in,
	input logic [`BRU_ADDR_W-1:0] addr_in,
	input logic [2:0] outcome_count,
	input logic [2:0] cmp_count,
	cmp_dispatch_if.outcome disp,
	output logic failure,
	output logic [`BRU_PATTERN_W-1:0] pattern_out,
	output logic [`BRU_ADDR_W-1:0] addr_out
);

	localparam int IDX_W = $clog2(`BRU_DEPTH);

	outcome_entry_t q [`BRU_DEPTH];
	outcome_entry_t resolved [`BRU_DEPTH];
	outcome_entry_t new_entry;
	logic [IDX_W-1:0] target;
	logic [2:0] fill;

	assign new_entry.pred_or_fail = prediction;
	assign new_entry.pattern = pattern_in;
	assign new_entry.addr = addr_in;

	// Resolved branches sit in front, so the oldest unresolved one is here
	assign target = IDX_W'(outcome_count - cmp_count);

	// XOR is applied before the commit shift moves the entry down
	always_comb begin
		for (int i = 0; i < `BRU_DEPTH; i++) begin
			resolved[i] = q[i];
			if (disp.fire && (target == IDX_W'(i))) begin
				resolved[i].pred_or_fail = q[i].pred_or_fail ^ disp.taken;
			end
		end
	end

	assign fill = outcome_count - 3'(commit_fire);

	for (genvar i = 0; i < `BRU_DEPTH; i++) begin : g_slot
		outcome_entry_t shifted;

		if (i < `BRU_DEPTH - 1) begin : g_mid
			assign shifted = commit_fire ? resolved[i+1] : resolved[i];
		end else begin : g_last
			assign shifted = resolved[i];
		end

		always_ff @(posedge clk) begin
			if (3'(i) < fill) begin
				q[i] <= shifted;
			end else if (issue_fire && (3'(i) == fill)) begin
				q[i] <= new_entry;
			end
		end
	end

	assign failure = q[0].pred_or_fail; // Only meaningful while commit_ready is high
	assign pattern_out = q[0].pattern;
	assign addr_out = q[0].addr;

endmodule

`default_nettype wire

//--- branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "bru_defines.svh"

module branch_unit
	import bru_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic issue_valid,
	output logic issue_ready,
	input cmp_kind_t kind,
	input logic use_imm,
	input logic [15:0] imm,
	input opd_t gpr_read [2],
	input opd_t fpr_read [2],
	input opd_t gpr_cdb,
	input opd_t fpr_cdb,
	input logic prediction,
	input logic [`BRU_PATTERN_W-1:0] pattern_in,
	input logic [`BRU_ADDR_W-1:0] addr_in,
	input logic commit_valid,
	output logic commit_ready,
	output logic failure,
	output logic [`BRU_PATTERN_W-1:0] pattern_out,
	output logic [`BRU_ADDR_W-1:0] addr_out
);

	logic issue_fire;
	logic commit_fire;
	logic [2:0] cmp_count;
	logic [2:0] outcome_count;

	cmp_dispatch_if disp ();

	branch_ctrl ctrl_i (
		.clk(clk),
		.rst_n(rst_n),
		.issue_valid(issue_valid),
		.issue_ready(issue_ready),
		.commit_valid(commit_valid),
		.commit_ready(commit_ready),
		.disp(disp.ctrl),
		.issue_fire(issue_fire),
		.commit_fire(commit_fire),
		.cmp_count(cmp_count),
		.outcome_count(outcome_count)
	);

	cmp_queue cmp_queue_i (
		.clk(clk),
		.rst_n(rst_n),
		.issue_fire(issue_fire),
		.kind(kind),
		.use_imm(use_imm),
		.imm(imm),
		.gpr_read(gpr_read),
		.fpr_read(fpr_read),
		.gpr_cdb(gpr_cdb),
		.fpr_cdb(fpr_cdb),
		.cmp_count(cmp_count),
		.disp(disp.queue)
	);

	cmp_eval cmp_eval_i (
		.disp(disp.eval)
	);

	outcome_queue outcome_queue_i (
		.clk(clk),
		.issue_fire(issue_fire),
		.commit_fire(commit_fire),
		.prediction(prediction),
		.pattern_in(pattern_in),
		.addr_in(addr_in),
		.outcome_count(outcome_count),
		.cmp_count(cmp_count),
		.disp(disp.outcome),
		.failure(failure),
		.pattern_out(pattern_out),
		.addr_out(addr_out)
	);

endmodule

`default_nettype wire

//--- tb_branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "bru_defines.svh"

module tb_branch_unit
	import bru_pkg::*;
;

	localparam int MAX_RECS = 64;
	localparam int TAG_W = `BRU_TAG_W;
	localparam int COMMIT_HOLD = 16; // Commits stay off this long so the queues fill up

	logic clk;
	logic rst_n;
	logic issue_valid;
	logic issue_ready;
	cmp_kind_t kind;
	logic use_imm;
	logic [15:0] imm;
	opd_t gpr_read [2];
	opd_t fpr_read [2];
	opd_t gpr_cdb;
	opd_t fpr_cdb;
	logic prediction;
	logic [`BRU_PATTERN_W-1:0] pattern_in;
	logic [`BRU_ADDR_W-1:0] addr_in;
	logic commit_valid;
	logic commit_ready;
	logic failure;
	logic [`BRU_PATTERN_W-1:0] pattern_out;
	logic [`BRU_ADDR_W-1:0] addr_out;

	// One test record per branch
	logic [1:0] r_kind [MAX_RECS];
	logic r_use_imm [MAX_RECS];
	logic [15:0] r_imm [MAX_RECS];
	logic [31:0] r_op [MAX_RECS][2];
	int r_d [MAX_RECS][2];
	logic r_pred [MAX_RECS];
	logic [`BRU_PATTERN_W-1:0] r_pat [MAX_RECS];
	logic [`BRU_ADDR_W-1:0] r_addr [MAX_RECS];
	logic r_exp [MAX_RECS];

	int pend [MAX_RECS]; // Needed operands still to come on a bus
	int arrive [MAX_RECS]; // Edge at which the last needed operand was present
	int due_at [2*MAX_RECS];
	int ev_q [$]; // Each scheduled bus word is numbered record * 2 + operand
	int cur_ev [2] = '{-1, -1};
	int n_recs = 0;
	int issued = 0;
	int committed = 0;
	int cyc = 0;
	int limit;
	logic [31:0] lcg = 32'h443;

	branch_unit branch_unit_i (.*);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	function automatic logic [31:0] lcg_next(logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic opd_t make_opd(logic v, logic [`BRU_TAG_W-1:0] tag, logic [31:0] data);
		opd_t o;
		o.valid = v;
		o.tag = tag;
		o.data = data;
		return o;
	endfunction

	function automatic logic [`BRU_TAG_W-1:0] opd_tag(int p, int j);
		return TAG_W'((p % 16) + 16 * j);
	endfunction

	function automatic int bus_of(int p);
		cmp_kind_t k;
		k = cmp_kind_t'(r_kind[p]);
		return (k == CMP_E || k == CMP_LE) ? 0 : 1; // 0 is the integer bus
	endfunction

	// Is-zero reads only operand 0 and an immediate replaces operand 1
	function automatic logic op_needed(int p, int j);
		if (j == 0)
			return 1'b1;
		return (cmp_kind_t'(r_kind[p]) != CMP_FZ) && !r_use_imm[p];
	endfunction

	task automatic report_failure(string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp)
			report_failure($sformatf("Mismatch at %0t: %s got %0b expected %0b",
				$time, name, got, exp));
	endtask

	task automatic check_pattern(string name, logic [`BRU_PATTERN_W-1:0] got,
			logic [`BRU_PATTERN_W-1:0] exp);
		if (got !== exp)
			report_failure($sformatf("Mismatch at %0t: %s got %h expected %h",
				$time, name, got, exp));
	endtask

	task automatic check_addr(string name, logic [`BRU_ADDR_W-1:0] got,
			logic [`BRU_ADDR_W-1:0] exp);
		if (got !== exp)
			report_failure($sformatf("Mismatch at %0t: %s got %h expected %h",
				$time, name, got, exp));
	endtask

	task automatic read_tests();
		int fd;
		int cnt;
		int k;
		int ui;
		int pr;
		int ex;
		string line;
		fd = $fopen("branch_unit_tests.txt", "r");
		if (fd == 0)
			report_failure("Could not open branch_unit_tests.txt");
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 1 && line.getc(0) != "#") begin
				if (n_recs >= MAX_RECS)
					report_failure("Too many records in branch_unit_tests.txt");
				cnt = $sscanf(line, "%d %d %h %h %h %d %d %d %h %h %d", k, ui,
					r_imm[n_recs], r_op[n_recs][0], r_op[n_recs][1], r_d[n_recs][0],
					r_d[n_recs][1], pr, r_pat[n_recs], r_addr[n_recs], ex);
				if (cnt != 11)
					report_failure($sformatf("Bad record line: %s", line));
				r_kind[n_recs] = 2'(k);
				r_use_imm[n_recs] = (ui != 0);
				r_pred[n_recs] = (pr != 0);
				r_exp[n_recs] = (ex != 0);
				n_recs++;
			end
		end
		$fclose(fd);
	endtask

	// Oldest due bus word for one bus, or -1 when the bus stays idle
	task automatic take_due(input int b, output int ev);
		int best;
		best = -1;
		ev = -1;
		for (int k = 0; k < ev_q.size(); k++) begin
			if (bus_of(ev_q[k] / 2) == b && due_at[ev_q[k]] <= cyc + 1) begin
				if (best < 0 || due_at[ev_q[k]] < due_at[ev_q[best]])
					best = k;
			end
		end
		if (best >= 0) begin
			ev = ev_q[best];
			ev_q.delete(best);
		end
	endtask

	task automatic step_cycle();
		int h;
		int p;
		int pb;
		int capj;
		int inflight;
		int e;
		opd_t word [2];
		logic busy [2];
		logic rdy;
		logic exp_ready;
		opd_t sel;
		opd_t oth;

		if (cyc > limit)
			report_failure($sformatf("Timeout after %0d cycles with %0d of %0d branches committed",
				cyc, committed, n_recs));
		for (int b = 0; b < 2; b++) begin
			if (cur_ev[b] >= 0 && op_needed(cur_ev[b] / 2, cur_ev[b] % 2)) begin
				pend[cur_ev[b] / 2]--;
				arrive[cur_ev[b] / 2] = cyc;
			end
		end

		inflight = issued - committed;
		// The oldest branch resolves one edge after it holds every operand it needs
		exp_ready = (inflight > 0) && (pend[committed] == 0) &&
			(cyc >= arrive[committed] + 2);
		check_bit("commit_ready", commit_ready, exp_ready);
		check_bit("issue_ready", issue_ready,
			(inflight < `BRU_DEPTH) || (commit_valid && exp_ready));

		if (commit_valid && exp_ready) begin
			h = committed;
			check_bit("failure", failure, r_exp[h]);
			check_pattern("pattern_out", pattern_out, r_pat[h]);
			check_addr("addr_out", addr_out, r_addr[h]);
			committed++;
		end
		if (issue_valid && issue_ready) begin
			p = issued;
			pend[p] = 0;
			arrive[p] = cyc;
			for (int j = 0; j < 2; j++) begin
				if (r_d[p][j] > 0) begin
					due_at[2 * p + j] = cyc + r_d[p][j];
					ev_q.push_back(2 * p + j);
					if (op_needed(p, j))
						pend[p]++;
				end
			end
			issued++;
		end

		lcg = lcg_next(lcg);
		commit_valid <= (cyc >= COMMIT_HOLD) && lcg[16];

		for (int b = 0; b < 2; b++) begin
			take_due(b, cur_ev[b]);
			e = cur_ev[b];
			busy[b] = (e >= 0);
			word[b] = busy[b] ? make_opd(1'b1, opd_tag(e / 2, e % 2), r_op[e / 2][e % 2]) :
				make_opd(1'b0, '0, '0);
		end

		if (issued < n_recs) begin
			p = issued;
			pb = bus_of(p);
			capj = -1;
			for (int j = 0; j < 2; j++) begin
				if (r_d[p][j] < 0)
					capj = j;
			end
			// A branch that captures in its issue cycle waits for a free bus
			if (capj >= 0 && busy[pb]) begin
				issue_valid <= 1'b0;
			end else begin
				issue_valid <= 1'b1;
				if (capj >= 0) begin
					word[pb] = make_opd(1'b1, opd_tag(p, capj), r_op[p][capj]);
					busy[pb] = 1'b1;
				end
			end
			kind <= cmp_kind_t'(r_kind[p]);
			use_imm <= r_use_imm[p];
			imm <= r_imm[p];
			prediction <= r_pred[p];
			pattern_in <= r_pat[p];
			addr_in <= r_addr[p];
			for (int j = 0; j < 2; j++) begin
				rdy = (r_d[p][j] == 0) && op_needed(p, j);
				sel = make_opd(rdy, opd_tag(p, j), rdy ? r_op[p][j] : ~r_op[p][j]);
				oth = make_opd(1'b1, opd_tag(p, j), ~r_op[p][j]); // The other file must be ignored
				gpr_read[j] <= (pb == 0) ? sel : oth;
				fpr_read[j] <= (pb == 0) ? oth : sel;
			end
		end else begin
			issue_valid <= 1'b0;
		end

		// An idle bus carries the other bus's tag with wrong data
		if (busy[0] && !busy[1])
			word[1] = make_opd(1'b1, word[0].tag, ~word[0].data);
		else if (busy[1] && !busy[0])
			word[0] = make_opd(1'b1, word[1].tag, ~word[1].data);
		gpr_cdb <= word[0];
		fpr_cdb <= word[1];
	endtask

	initial begin
		rst_n <= 1'b0;
		issue_valid <= 1'b0;
		kind <= CMP_E;
		use_imm <= 1'b0;
		imm <= '0;
		gpr_read <= '{'0, '0};
		fpr_read <= '{'0, '0};
		gpr_cdb <= '0;
		fpr_cdb <= '0;
		prediction <= 1'b0;
		pattern_in <= '0;
		addr_in <= '0;
		commit_valid <= 1'b0;
		read_tests();
		limit = 40 * n_recs + 100;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		while (committed < n_recs) begin
			@(posedge clk);
			cyc++;
			step_cycle();
		end
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- branch_unit_tests.txt
# kind(0 fz,1 fle,2 e,3 le) use_imm imm op0 op1 delay0 delay1 pred pattern addr fail
# delay 0 ready at issue, -1 on the bus in the issue cycle, n on the bus n cycles later
2 0 0000 00000005 00000005 0 0 1 a1 0100 0
2 0 0000 00000005 00000006 0 0 1 a2 0104 1
3 0 0000 fffffffe 00000003 0 0 0 a3 0108 1
3 0 0000 00000007 fffffff0 0 0 0 a4 010c 0
3 1 fff0 fffffff0 00000000 0 0 1 b5 0110 0
2 1 8000 ffff8000 00000000 0 0 0 b6 0114 1
3 1 0010 00000011 00000000 0 0 1 b7 0118 1
1 0 0000 3f800000 40000000 0 0 0 c8 2000 1
1 0 0000 40000000 3f800000 0 0 1 c9 2004 1
1 0 0000 bf800000 3f800000 0 0 1 ca 2008 0
1 0 0000 3f800000 bf800000 0 0 0 cb 200c 0
1 0 0000 c0000000 bf800000 0 0 0 cc 2010 1
1 0 0000 bf800000 c0000000 0 0 1 cd 2014 1
1 0 0000 80000000 00000000 0 0 0 ce 2018 1
1 0 0000 00000000 80000000 0 0 1 cf 201c 0
1 0 0000 3fc00000 3fc00000 0 0 0 d0 2020 1
0 0 0000 00000000 00000000 0 0 1 d1 3000 0
0 0 0000 80000001 00000000 0 9 0 d2 3004 1
0 0 0000 3f800000 00000000 0 0 1 d3 3008 1
2 0 0000 00001234 00001234 3 0 0 e4 1000 1
3 0 0000 00000010 00000020 -1 5 1 e5 1004 0
1 0 0000 40400000 40400001 0 7 1 e6 1008 0
0 0 0000 c1200000 00000000 -1 0 0 e7 100c 0
2 0 0000 abcd0000 abcd0001 2 2 1 e8 1010 1
3 1 7fff 00008000 00000000 4 0 0 e9 1014 0
1 0 0000 c2c80000 c2c80000 1 -1 0 ea 1018 1
2 0 0000 00000000 00000000 0 -1 1 eb 101c 0
3 0 0000 80000000 7fffffff 6 6 1 ec 1020 0
1 0 0000 7f7fffff ff7fffff 0 3 1 ed 1024 1
0 0 0000 807fffff 00000000 2 0 1 ee 1028 0

//--- branch_unit.f
+incdir+.
bru_pkg.sv
bru_if.sv
branch_ctrl.sv
cmp_queue.sv
cmp_eval.sv
outcome_queue.sv
branch_unit.sv
tb_branch_unit.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_branch_unit
RTL_TOP ?= branch_unit
FILELIST ?= branch_unit.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG := Simulation finished: PASS

SIM := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST) | grep -v '^+') bru_defines.svh

.PHONY: all run lint clean

all: run

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
